// ==== bench/bp_checker.sv ====
// --------------------
// compares each prediction with the values queued at its lookup
// a result is due exactly one cycle after its lookup
// outputs are sampled on the falling edge
// --------------------
`timescale 1ns/1ps
`default_nettype none

module bp_checker import bp_pkg::*; #(
    parameter int queue_depth = 4
) (
    input wire logic         clk,
    input wire logic         rst_n,
    input wire logic         lookup_valid,
    input wire logic [127:0] test_name,
    input wire logic         exp_taken,
    input wire pc_t          exp_target,
    input wire counter_t     exp_state,
    input wire logic         res_valid,
    input wire logic         credit_return,
    input wire logic         pred_valid,
    input wire logic         pred_taken,
    input wire pc_t          pred_target,
    input wire counter_t     pred_state
);

    // cycle [194:163], test name [162:35], taken [34], state [33:32], target [31:0]
    logic [194:0] pending_q [$];
    logic [194:0] head;

    int value_errors    = 0;
    int protocol_errors = 0;
    int cycle           = 0;
    int credits         = queue_depth;   // sender's view of its credits

    task automatic compare(logic [127:0] name, string field, logic [31:0] exp,
                           logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %0s %0s: expected %0h, actual %0h", name, field, exp, act);
            value_errors++;
        end
    endtask

    always @(negedge clk) begin
        cycle++;
        if (!rst_n) begin
            pending_q.delete();
            credits = queue_depth;
        end else begin
            if (pred_valid) begin
                if (pending_q.size() == 0) begin
                    $display("prediction valid at cycle %0d with no lookup pending", cycle);
                    protocol_errors++;
                end else begin
                    head = pending_q.pop_front();
                    compare(head[162:35], "taken", head[34], pred_taken);
                    compare(head[162:35], "state", head[33:32], pred_state);
                    compare(head[162:35], "target", head[31:0], pred_target);
                end
            end
            // anything older than this cycle missed its slot
            if (pending_q.size() > 0 && int'(pending_q[0][194:163]) < cycle) begin
                head = pending_q.pop_front();
                $display("no prediction one cycle after the %0s lookup of cycle %0d",
                         head[162:35], head[194:163]);
                protocol_errors++;
            end
            if (lookup_valid) begin
                pending_q.push_back({cycle, test_name, exp_taken, exp_state, exp_target});
            end

            // only entries accepted at earlier edges can give a credit back
            if (credit_return) credits++;
            if (credits > queue_depth) begin
                $display("credit count %0d above the queue depth at cycle %0d", credits, cycle);
                protocol_errors++;
                credits = queue_depth;
            end
            if (res_valid) credits--;   // spent on the entry taken at the next edge
        end
    end

endmodule

`default_nettype wire

// ==== bench/bp_stimulus.txt ====
# resolve <pc> <taken> <target>                              numbers in hex
# lookup <test> <pc> <exp_taken> <exp_target> <exp_state>    drain waits for all credits
lookup reset 00001000 0 00001004 0
lookup reset 00001004 0 00001008 0
lookup reset 0000200c 0 00002010 0
resolve 00001040 1 00003000
resolve 00001040 1 00003000
drain
lookup train_weak 00001040 1 00003000 2
resolve 00001040 1 00003000
drain
lookup train_strong 00001040 1 00003000 3
resolve 00001040 1 00003000
drain
lookup train_sat 00001040 1 00003000 3
resolve 00001040 0 00000000
drain
lookup train_down 00001040 1 00003000 2
resolve 00001040 0 00000000
resolve 00001040 0 00000000
drain
lookup train_nt 00001040 0 00003000 0
resolve 00001040 1 00003000
resolve 00001040 1 00003000
drain
lookup alias_miss 00001440 0 00001444 2
lookup alias_hit 00001040 1 00003000 2
resolve 00002004 1 00005000
resolve 00002008 0 00007000
resolve 00002004 1 00006000
resolve 00002008 1 00007000
resolve 00002004 1 00006000
resolve 00002008 1 00007000
drain
lookup credit_order 00002004 1 00006000 3
lookup credit_order 00002008 1 00007000 2
lookup b2b 00002004 1 00006000 3
lookup b2b 00001000 0 00001004 0
lookup b2b 00002008 1 00007000 2
lookup b2b 00001440 0 00001444 2
lookup b2b 0000200c 0 00002010 0

// ==== bench/tb_branch_predictor.sv ====
// --------------------
// commands and expected values come from bench/bp_stimulus.txt
// run from the project root so that path resolves
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor import bp_pkg::*; ();

    localparam int queue_depth = default_queue_depth;
    localparam stim_path = "bench/bp_stimulus.txt";

    logic         clk = 1'b0;
    logic         rst_n;
    logic         lookup_valid;
    pc_t          lookup_pc;
    logic         res_valid;
    pc_t          res_pc;
    logic         res_taken;
    pc_t          res_target;
    logic         credit_return;
    logic         pred_valid;
    logic         pred_taken;
    pc_t          pred_target;
    counter_t     pred_state;

    logic [127:0] test_name;   // expected values travel with each lookup
    logic         exp_taken;
    pc_t          exp_target;
    counter_t     exp_state;

    logic [31:0]  lfsr = 32'h53f15307;
    int           credits;
    int           line_count = 0;
    int           stim_errors = 0;

    always #10 clk = ~clk;

    branch_predictor #(
        .queue_depth (queue_depth)
    ) branch_predictor_inst (
        .clk (clk), .rst_n (rst_n),
        .lookup_valid (lookup_valid), .lookup_pc (lookup_pc),
        .res_valid (res_valid), .res_pc (res_pc),
        .res_taken (res_taken), .res_target (res_target),
        .credit_return (credit_return), .pred_valid (pred_valid),
        .pred_taken (pred_taken), .pred_target (pred_target), .pred_state (pred_state)
    );

    bp_checker #(
        .queue_depth (queue_depth)
    ) checker_inst (
        .clk (clk), .rst_n (rst_n), .lookup_valid (lookup_valid),
        .test_name (test_name), .exp_taken (exp_taken),
        .exp_target (exp_target), .exp_state (exp_state),
        .res_valid (res_valid), .credit_return (credit_return),
        .pred_valid (pred_valid), .pred_taken (pred_taken),
        .pred_target (pred_target), .pred_state (pred_state)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic tick();
        @(posedge clk);
        if (credit_return) credits++;   // pulse seen in the cycle just ended
    endtask

    task automatic drive_idle();
        res_valid    <= 1'b0;
        lookup_valid <= 1'b0;
    endtask

    task automatic send_resolve(pc_t pc, logic taken, pc_t target);
        int gap;
        gap = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr);
            gap  = gap * 2 + lfsr[0];
        end
        repeat (gap) begin
            drive_idle();
            tick();
        end
        while (credits == 0) begin   // stall until a credit comes back
            drive_idle();
            tick();
        end
        lookup_valid <= 1'b0;
        res_valid    <= 1'b1;
        res_pc       <= pc;
        res_taken    <= taken;
        res_target   <= target;
        credits--;
        tick();
    endtask

    task automatic drain_queue();
        while (credits < queue_depth) begin
            drive_idle();
            tick();
        end
        drive_idle();
        repeat (2) tick();
    endtask

    task automatic send_lookup(logic [127:0] name, pc_t pc, logic taken, pc_t target,
                               counter_t state);
        res_valid    <= 1'b0;
        lookup_valid <= 1'b1;
        lookup_pc    <= pc;
        test_name    <= name;
        exp_taken    <= taken;
        exp_target   <= target;
        exp_state    <= state;
        tick();
    endtask

    task automatic run_command(string line);
        logic [127:0] cmd;
        logic [127:0] name;
        logic [31:0]  pc;
        logic [31:0]  f1;
        logic [31:0]  f2;
        logic [31:0]  f3;
        int           n;
        n = $sscanf(line, "%s", cmd);
        if (n <= 0 || line.getc(0) == 8'h23) begin
            return;   // blank or comment
        end
        if (cmd == "resolve" && $sscanf(line, "%s %h %h %h", cmd, pc, f1, f2) == 4) begin
            send_resolve(pc, f1[0], f2);
        end else if (cmd == "lookup" &&
                     $sscanf(line, "%s %s %h %h %h %h", cmd, name, pc, f1, f2, f3) == 6) begin
            send_lookup(name, pc, f1[0], f2, f3[1:0]);
        end else if (cmd == "drain") begin
            drain_queue();
        end else begin
            $display("stimulus line not understood: %s", line);
            stim_errors++;
        end
    endtask

    initial begin
        int    fd;
        string line;
        rst_n        = 1'b0;
        lookup_valid = 1'b0;
        lookup_pc    = '0;
        res_valid    = 1'b0;
        res_pc       = '0;
        res_taken    = 1'b0;
        res_target   = '0;
        test_name    = '0;
        exp_taken    = 1'b0;
        exp_target   = '0;
        exp_state    = strong_not_taken;
        credits      = queue_depth;

        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %0s", stim_path);
            $display("STATUS: FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) line_count++;   // sizes the watchdog
            $fclose(fd);
            fd = $fopen(stim_path, "r");

            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            while ($fgets(line, fd) > 0) begin
                run_command(line);
            end
            $fclose(fd);
            drive_idle();
            repeat (4) tick();

            $display("errors: value %0d, protocol %0d, stimulus %0d",
                     checker_inst.value_errors, checker_inst.protocol_errors, stim_errors);
            if (checker_inst.value_errors + checker_inst.protocol_errors + stim_errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (line_count > 0);
        repeat (line_count * 20 + 200) @(posedge clk);
        $display("timeout after %0d cycles, the stimulus did not complete",
                 line_count * 20 + 200);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/bp_pkg.sv
rtl/bp_resolve_queue.sv
rtl/bp_history_table.sv
rtl/bp_target_buffer.sv
rtl/bp_predict_stage.sv
rtl/branch_predictor.sv
bench/bp_checker.sv
bench/tb_branch_predictor.sv

// ==== rtl/bp_history_table.sv ====
// --------------------
// two-bit saturating counters, one lookup and one update port
// lookup read is registered, lookup sees the old value on a collision
// --------------------
`timescale 1ns/1ps
`default_nettype none

module bp_history_table import bp_pkg::*; #(
    parameter int unsigned index_bits = 8
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire pc_t      lookup_pc,
    input  wire logic     upd_valid,
    input  wire pc_t      upd_pc,
    input  wire logic     upd_taken,
    output counter_t      lookup_state
);

    localparam int unsigned num_entries = 2 ** index_bits;

    typedef logic [index_bits-1:0] bht_index_t;

    counter_t   counters [num_entries];
    bht_index_t lookup_idx;
    bht_index_t upd_idx;

    assign lookup_idx = lookup_pc[pc_index_lsb +: index_bits];
    assign upd_idx    = upd_pc[pc_index_lsb +: index_bits];

    // saturating step through the counter states
    function automatic counter_t next_state(counter_t cur, logic taken);
        counter_e st;
        counter_e nxt;
        st = counter_e'(cur);
        case (st)
            strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   nxt = taken ? weak_taken : strong_not_taken;
            weak_taken:       nxt = taken ? strong_taken : weak_not_taken;
            strong_taken:     nxt = taken ? strong_taken : weak_taken;
            default:          nxt = strong_not_taken;
        endcase
        return counter_t'(nxt);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // whole table cleared in the reset cycle
            for (int i = 0; i < num_entries; i++) begin
                counters[i] <= strong_not_taken;
            end
            lookup_state <= strong_not_taken;
        end else begin
            if (upd_valid) begin
                counters[upd_idx] <= next_state(counters[upd_idx], upd_taken);
            end
            lookup_state <= counters[lookup_idx];   // old value on same-index update
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bp_pkg.sv ====
// --------------------
// shared types and parameter defaults for the branch predictor
// table index bits start at pc bit 2, so pcs are word aligned
// --------------------
`default_nettype none

package bp_pkg;

    // program counter or target address
    typedef logic [31:0] pc_t;

    // raw two-bit counter, upper bit is the taken prediction
    typedef logic [1:0] counter_t;

    typedef enum counter_t {
        strong_not_taken = 2'd0,
        weak_not_taken   = 2'd1,
        weak_taken       = 2'd2,
        strong_taken     = 2'd3
    } counter_e;

    // lowest pc bit used for any table index
    localparam int unsigned pc_index_lsb = 2;

    // defaults handed down by the top level
    localparam int unsigned default_index_bits     = 8;   // 256 counters
    localparam int unsigned default_btb_index_bits = 4;   // 16 entries
    localparam int unsigned default_queue_depth    = 4;

endpackage

`default_nettype wire

// ==== rtl/bp_predict_stage.sv ====
// --------------------
// aligns the lookup with the registered table results
// taken needs both counter direction and a target buffer hit
// --------------------
`timescale 1ns/1ps
`default_nettype none

module bp_predict_stage import bp_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     lookup_valid,
    input  wire pc_t      lookup_pc,
    input  wire counter_t lookup_state,
    input  wire logic     lookup_hit,
    input  wire pc_t      lookup_target,
    output logic          pred_valid,
    output logic          pred_taken,
    output pc_t           pred_target,
    output counter_t      pred_state
);

    logic valid_q;
    pc_t  pc_q;   // pc of the lookup now leaving the tables

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= lookup_valid;
        end
    end

    always_ff @(posedge clk) begin
        pc_q <= lookup_pc;
    end

    assign pred_valid  = valid_q;
    assign pred_state  = lookup_state;
    assign pred_taken  = lookup_state[1] && lookup_hit;
    assign pred_target = lookup_hit ? lookup_target : pc_q + 32'd4;   // fall-through on a miss

endmodule

`default_nettype wire

// ==== rtl/bp_resolve_queue.sv ====
// --------------------
// sender needs a credit for each res_valid cycle
// overflow is not detected
// one entry retires per cycle and returns its credit
// --------------------
`timescale 1ns/1ps
`default_nettype none

module bp_resolve_queue import bp_pkg::*; #(
    parameter int unsigned queue_depth = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic res_valid,
    input  wire pc_t  res_pc,
    input  wire logic res_taken,
    input  wire pc_t  res_target,
    output logic      upd_valid,
    output pc_t       upd_pc,
    output logic      upd_taken,
    output pc_t       upd_target,
    output logic      credit_return
);

    localparam int ptr_bits = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_bits = $clog2(queue_depth + 1);

    typedef logic [ptr_bits-1:0] ptr_t;
    typedef logic [cnt_bits-1:0] cnt_t;

    pc_t  pc_mem     [queue_depth];
    logic taken_mem  [queue_depth];
    pc_t  target_mem [queue_depth];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;     // entries waiting in the buffer
    logic pop;

    function automatic ptr_t ptr_inc(ptr_t p);
        return (p == ptr_t'(queue_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop = (count != '0);   // head moves to the output register

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            upd_valid <= 1'b0;
        end else begin
            if (res_valid) wr_ptr <= ptr_inc(wr_ptr);
            if (pop) rd_ptr <= ptr_inc(rd_ptr);
            upd_valid <= pop;
            case ({res_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload store and head register
    always_ff @(posedge clk) begin
        if (res_valid) begin
            pc_mem[wr_ptr]     <= res_pc;
            taken_mem[wr_ptr]  <= res_taken;
            target_mem[wr_ptr] <= res_target;
        end
        if (pop) begin
            upd_pc     <= pc_mem[rd_ptr];
            upd_taken  <= taken_mem[rd_ptr];
            upd_target <= target_mem[rd_ptr];
        end
    end

    // slot was freed one cycle earlier, so the credit is always safe
    assign credit_return = upd_valid;

endmodule

`default_nettype wire

// ==== rtl/bp_target_buffer.sv ====
// --------------------
// direct-mapped branch target buffer, written on taken updates only
// tag is every pc bit above the index, hit and target are registered
// --------------------
`timescale 1ns/1ps
`default_nettype none

module bp_target_buffer import bp_pkg::*; #(
    parameter int unsigned btb_index_bits = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire pc_t  lookup_pc,
    input  wire logic upd_valid,
    input  wire pc_t  upd_pc,
    input  wire logic upd_taken,
    input  wire pc_t  upd_target,
    output logic      lookup_hit,
    output pc_t       lookup_target
);

    localparam int unsigned num_entries = 2 ** btb_index_bits;
    localparam int unsigned tag_lsb     = pc_index_lsb + btb_index_bits;
    localparam int unsigned tag_bits    = $bits(pc_t) - tag_lsb;

    typedef logic [btb_index_bits-1:0] btb_index_t;
    typedef logic [tag_bits-1:0]       tag_t;

    logic [num_entries-1:0] valid;
    tag_t                   tag_mem    [num_entries];
    pc_t                    target_mem [num_entries];

    btb_index_t lookup_idx;
    btb_index_t upd_idx;
    tag_t       lookup_tag;
    tag_t       upd_tag;
    logic       wr_en;

    assign lookup_idx = lookup_pc[pc_index_lsb +: btb_index_bits];
    assign upd_idx    = upd_pc[pc_index_lsb +: btb_index_bits];
    assign lookup_tag = lookup_pc[tag_lsb +: tag_bits];
    assign upd_tag    = upd_pc[tag_lsb +: tag_bits];

    assign wr_en = upd_valid && upd_taken;   // not-taken leaves the entry alone

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    // tag and target store
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[upd_idx]    <= upd_tag;
            target_mem[upd_idx] <= upd_target;
        end
    end

    // compare at lookup, result lands next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lookup_hit <= 1'b0;
        end else begin
            lookup_hit <= valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
        end
    end

    always_ff @(posedge clk) begin
        lookup_target <= target_mem[lookup_idx];   // only meaningful with lookup_hit
    end

endmodule

`default_nettype wire

// ==== rtl/branch_predictor.sv ====
// --------------------
// branch predictor top, lookups are never stalled
// resolutions need a credit, queue_depth credits after reset
// --------------------
`timescale 1ns/1ps
`default_nettype none

module branch_predictor import bp_pkg::*; #(
    parameter int unsigned index_bits     = default_index_bits,
    parameter int unsigned btb_index_bits = default_btb_index_bits,
    parameter int unsigned queue_depth    = default_queue_depth
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic lookup_valid,
    input  wire pc_t  lookup_pc,
    input  wire logic res_valid,
    input  wire pc_t  res_pc,
    input  wire logic res_taken,
    input  wire pc_t  res_target,
    output logic      credit_return,
    output logic      pred_valid,
    output logic      pred_taken,
    output pc_t       pred_target,
    output counter_t  pred_state
);

    // queue to tables
    logic     upd_valid;
    pc_t      upd_pc;
    logic     upd_taken;
    pc_t      upd_target;

    // tables to prediction stage
    counter_t lookup_state;
    logic     lookup_hit;
    pc_t      lookup_target;

    bp_resolve_queue #(
        .queue_depth (queue_depth)
    ) resolve_queue_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_valid     (res_valid),
        .res_pc        (res_pc),
        .res_taken     (res_taken),
        .res_target    (res_target),
        .upd_valid     (upd_valid),
        .upd_pc        (upd_pc),
        .upd_taken     (upd_taken),
        .upd_target    (upd_target),
        .credit_return (credit_return)
    );

    bp_history_table #(
        .index_bits (index_bits)
    ) history_table_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_pc    (lookup_pc),
        .upd_valid    (upd_valid),
        .upd_pc       (upd_pc),
        .upd_taken    (upd_taken),
        .lookup_state (lookup_state)
    );

    bp_target_buffer #(
        .btb_index_bits (btb_index_bits)
    ) target_buffer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_pc     (lookup_pc),
        .upd_valid     (upd_valid),
        .upd_pc        (upd_pc),
        .upd_taken     (upd_taken),
        .upd_target    (upd_target),
        .lookup_hit    (lookup_hit),
        .lookup_target (lookup_target)
    );

    bp_predict_stage predict_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_valid  (lookup_valid),
        .lookup_pc     (lookup_pc),
        .lookup_state  (lookup_state),
        .lookup_hit    (lookup_hit),
        .lookup_target (lookup_target),
        .pred_valid    (pred_valid),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .pred_state    (pred_state)
    );

endmodule

`default_nettype wire
